/* bench/pingpong_tb.sv */
`timescale 1ns/1ps
`include "pingpong_macros.svh"

module pingpong_tb;
    import pingpong_pkg::*;

    // the full sequence needs about 6000 cycles, so three times that is ample.
    localparam int MAX_CYCLES = 20000;

    logic       clk;
    logic       rst_n;
    axil_req_t  req;
    axil_rsp_t  rsp;
    logic       btn;
    count_t     count;
    logic       direction;
    logic [7:0] seg;
    logic [3:0] an;

    int         cycles = 0;
    int         changes = 0;
    int         seed;
    count_t     prev_count;
    count_t     m_count;   // reference model state.
    count_t     m_min;
    count_t     m_max;
    logic       m_up;
    logic       m_pending;
    logic       m_en;

    tb_clock clock_i (.clk(clk));

    pingpong_top dut_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .axil_req  (req),
        .axil_rsp  (rsp),
        .btn       (btn),
        .count     (count),
        .direction (direction),
        .seg       (seg),
        .an        (an)
    );

    task automatic fail_with(input string msg);
        $display("error at %0t: %s", $time, msg);
        $display("Simulation failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s is %0h, expected %0h", $time, name, got, exp);
            $display("Simulation failed");
            $fatal(1, "value check failed");
        end
    endtask

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES)
            fail_with("timeout, the tests did not finish in time");
    end

    // one step of the bounce rule, applied for every observed count change.
    task automatic advance_model;
        if (m_count < m_min || m_count > m_max) begin
            m_count = m_min;
            m_up = 1'b1;
        end else begin
            if (m_pending)
                m_up = ~m_up;
            m_pending = 1'b0;
            if (m_up) begin
                if (m_count < m_max) begin
                    m_count = m_count + 1'b1;
                end else begin
                    m_count = m_count - 1'b1;
                    m_up = 1'b0;
                end
            end else if (m_count > m_min) begin
                m_count = m_count - 1'b1;
            end else begin
                m_count = m_count + 1'b1;
                m_up = 1'b1;
            end
        end
    endtask

    always @(negedge clk) begin
        if (rst_n) begin
            prev_count = count;
        end else begin
            if (count !== prev_count) begin
                if (!(m_en && m_min < m_max))
                    fail_with("count moved while counting was stopped");
                advance_model();
                check("count", count, m_count);
                changes++;
            end
            check("direction", direction, m_up);
            prev_count = count;
        end
    end

    task automatic axil_write(input axil_addr_t addr, input axil_data_t data,
                              output axil_resp_t resp);
        req.awaddr = addr;
        req.wdata = data;
        req.wstrb = '1;
        req.awvalid = 1'b1;
        req.wvalid = 1'b1;
        req.bready = 1'b1;
        do @(negedge clk); while (!rsp.awready);
        @(posedge clk);
        #1;
        req.awvalid = 1'b0;
        req.wvalid = 1'b0;
        do @(negedge clk); while (!rsp.bvalid);
        resp = rsp.bresp;
        @(posedge clk);
        #1;
        req.bready = 1'b0;
        if (resp == `PP_RESP_OKAY) begin   // the DUT uses new values from here on.
            case (addr)
                `PP_REG_CTRL:   m_en = data[0];
                `PP_REG_LIMITS: begin
                    m_min = data[3:0];
                    m_max = data[11:8];
                end
                `PP_REG_FLIP:   if (data[0]) m_pending = 1'b1;
                default: ;
            endcase
        end
    endtask

    task automatic axil_read(input axil_addr_t addr, output axil_data_t data,
                             output axil_resp_t resp);
        req.araddr = addr;
        req.arvalid = 1'b1;
        req.rready = 1'b1;
        do @(negedge clk); while (!rsp.arready);
        @(posedge clk);
        #1;
        req.arvalid = 1'b0;
        do @(negedge clk); while (!rsp.rvalid);
        data = rsp.rdata;
        resp = rsp.rresp;
        @(posedge clk);
        #1;
        req.rready = 1'b0;
    endtask

    task automatic write_reg(input axil_addr_t addr, input axil_data_t data);
        axil_resp_t resp;
        axil_write(addr, data, resp);
        check("bresp", resp, `PP_RESP_OKAY);
    endtask

    task automatic read_reg(input axil_addr_t addr, output axil_data_t data);
        axil_resp_t resp;
        axil_read(addr, data, resp);
        check("rresp", resp, `PP_RESP_OKAY);
    endtask

    task automatic wait_changes(input int n);
        int target;
        target = changes + n;
        while (changes < target) @(negedge clk);
        @(posedge clk);
        #1;
    endtask

    task automatic skip_cycles(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    function automatic logic [7:0] digit_code(input int value);
        logic [7:0] table_a2dp [10] = '{8'h03, 8'h9F, 8'h25, 8'h0D, 8'h99,
                                        8'h49, 8'h41, 8'h1F, 8'h01, 8'h09};
        return table_a2dp[value];
    endfunction

    task automatic scan_digits;
        logic [7:0] exp;
        skip_cycles(4 * `PP_SCAN_DIV);   // a full scan with the count frozen.
        for (int d = 0; d < 4; d++) begin
            while (an !== ~(4'b0001 << d)) @(negedge clk);
            case (d)
                0:       exp = digit_code(m_count % 10);
                1:       exp = digit_code(m_count / 10);
                default: exp = m_up ? 8'b0011_1011 : 8'b1100_0111;
            endcase
            check("seg", seg, exp);
        end
        skip_cycles(1);
    endtask

    task automatic register_access;
        axil_data_t d;
        axil_resp_t resp;
        read_reg(`PP_REG_PERIOD, d);
        check("period after reset", d, 1);
        read_reg(`PP_REG_LIMITS, d);
        check("limits after reset", d, 0);
        write_reg(`PP_REG_LIMITS, 32'h0000_0903);
        write_reg(`PP_REG_PERIOD, 32'd4);
        write_reg(`PP_REG_CTRL, 32'd1);
        read_reg(`PP_REG_LIMITS, d);
        check("limits", d, 32'h0000_0903);
        read_reg(`PP_REG_PERIOD, d);
        check("period", d, 32'd4);
        read_reg(`PP_REG_CTRL, d);
        check("ctrl", d, 32'd1);
        axil_write(4'h2, 32'd1, resp);
        check("bresp unused", resp, `PP_RESP_SLVERR);
        axil_read(4'h6, d, resp);
        check("rresp unused", resp, `PP_RESP_SLVERR);
        check("rdata unused", d, 0);
    endtask

    task automatic flip_requests;
        axil_data_t d;
        write_reg(`PP_REG_FLIP, 32'd1);
        wait_changes(3);
        write_reg(`PP_REG_PERIOD, 32'd100);   // room for two writes between ticks.
        wait_changes(2);
        write_reg(`PP_REG_FLIP, 32'd1);
        write_reg(`PP_REG_FLIP, 32'd1);
        wait_changes(2);
        write_reg(`PP_REG_CTRL, 32'd0);
        read_reg(`PP_REG_STATUS, d);
        check("status count", d[3:0], count);
        check("status direction", d[8], direction);
        scan_digits();   // count below ten here.
        write_reg(`PP_REG_PERIOD, 32'd4);
        write_reg(`PP_REG_CTRL, 32'd1);
    endtask

    task automatic range_changes;
        int     rnd;
        count_t lo;
        count_t hi;
        count_t tmp;
        count_t held;
        write_reg(`PP_REG_LIMITS, 32'h0000_0F0C);   // count sits below the new min.
        wait_changes(1);
        check("reload count", count, 12);
        check("reload direction", direction, 1);
        repeat (4) begin
            rnd = $random(seed);
            lo = rnd[3:0];
            hi = rnd[7:4];
            if (lo > hi) begin
                tmp = lo;
                lo = hi;
                hi = tmp;
            end else if (lo == hi) begin
                if (hi < 15) hi = hi + 1'b1;
                else lo = lo - 1'b1;
            end
            write_reg(`PP_REG_LIMITS, {20'h0, hi, 4'h0, lo});
            wait_changes(8);
        end
        write_reg(`PP_REG_LIMITS, 32'h0000_0509);   // min above max.
        held = count;
        skip_cycles(50 * 4);
        check("count with min above max", count, held);
        write_reg(`PP_REG_LIMITS, 32'h0000_0903);
        write_reg(`PP_REG_CTRL, 32'd0);
        held = count;
        skip_cycles(50 * 4);
        check("count while disabled", count, held);
    endtask

    task automatic button_presses;
        write_reg(`PP_REG_CTRL, 32'd1);
        wait_changes(3);   // back between 3 and 9.
        write_reg(`PP_REG_CTRL, 32'd0);
        write_reg(`PP_REG_LIMITS, 32'h0000_0F00);   // a flip now always shows.
        btn = 1'b1;   // shorter than the debounce window.
        skip_cycles(2);
        btn = 1'b0;
        skip_cycles(10);
        write_reg(`PP_REG_CTRL, 32'd1);
        wait_changes(1);
        write_reg(`PP_REG_CTRL, 32'd0);
        btn = 1'b1;
        skip_cycles(20);
        m_pending = 1'b1;   // one press latched while stopped.
        write_reg(`PP_REG_CTRL, 32'd1);
        wait_changes(4);   // still held, so no further flips.
        btn = 1'b0;
        wait_changes(2);
    endtask

    task automatic display_readout;
        write_reg(`PP_REG_LIMITS, 32'h0000_0E0A);
        wait_changes(3);
        write_reg(`PP_REG_CTRL, 32'd0);
        scan_digits();
        write_reg(`PP_REG_CTRL, 32'd1);
        wait_changes(4);
        write_reg(`PP_REG_CTRL, 32'd0);
        scan_digits();
    endtask

    initial begin
        req = '0;
        btn = 1'b0;
        rst_n = 1'b1;
        seed = 91;
        m_count = '0;
        m_min = '0;
        m_max = '0;
        m_up = 1'b1;
        m_pending = 1'b0;
        m_en = 1'b0;
        prev_count = '0;
        skip_cycles(5);
        rst_n = 1'b0;
        check("an after reset", an, 4'hF);
        check("count after reset", count, 0);
        check("direction after reset", direction, 1);
        register_access();
        wait_changes(20);   // bounce between 3 and 9.
        flip_requests();
        range_changes();
        button_presses();
        display_readout();
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

/* bench/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
    parameter real PERIOD_NS = 4.0
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2.0) clk = ~clk;   // free running.
    end

endmodule

/* pingpong.f */
+incdir+source
source/pingpong_pkg.sv
source/pingpong_regs.sv
source/button_conditioner.sv
source/step_timer.sv
source/pingpong_counter.sv
source/seg_scan.sv
source/pingpong_top.sv
bench/tb_clock.sv
bench/pingpong_tb.sv

/* source/button_conditioner.sv */
`timescale 1ns/1ps
`include "pingpong_macros.svh"

module button_conditioner #(
    parameter int DEBOUNCE_LEN = `PP_DEBOUNCE_LEN
) (
    input  logic clk,
    input  logic rst_n,
    input  logic btn,
    output logic press
);

    logic [DEBOUNCE_LEN-1:0] history;
    logic                    stable;
    logic                    stable_q;

    assign stable = &history;   // level counts only after a full run of ones.

    always_ff @(posedge clk) begin
        if (rst_n) begin
            history <= '0;
            stable_q <= 1'b0;
            press <= 1'b0;
        end else begin
            history <= {history[DEBOUNCE_LEN-2:0], btn};
            stable_q <= stable;
            press <= stable & ~stable_q;   // rising edge of the clean level.
        end
    end

endmodule

/* source/pingpong_counter.sv */
`timescale 1ns/1ps

module pingpong_counter (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     step,
    input  logic                     flip_cmd,
    input  logic                     flip_btn,
    input  pingpong_pkg::pp_cfg_t    cfg,
    output pingpong_pkg::pp_status_t status
);
    import pingpong_pkg::*;

    count_t count;
    dir_t   direction;
    logic   flip_pending;
    logic   pending_eff;
    logic   range_ok;
    logic   in_range;
    logic   tick;
    dir_t   step_dir;
    count_t next_count;
    dir_t   next_dir;
    logic   next_pending;

    assign pending_eff = flip_pending | flip_cmd | flip_btn;
    assign range_ok = cfg.min < cfg.max;
    assign in_range = (count >= cfg.min) && (count <= cfg.max);
    assign tick = step && cfg.enable && range_ok;
    assign step_dir = pending_eff ? dir_t'(~direction) : direction;

    always_comb begin
        next_count = count;
        next_dir = direction;
        next_pending = pending_eff;   // requests pile up into one until used.
        if (tick) begin
            if (!in_range) begin
                next_count = cfg.min;   // limits moved past us.
                next_dir = DIR_UP;
            end else begin
                next_pending = 1'b0;
                if (step_dir == DIR_UP) begin
                    if (count < cfg.max) begin
                        next_count = count + 1'b1;
                        next_dir = DIR_UP;
                    end else begin
                        next_count = count - 1'b1;
                        next_dir = DIR_DOWN;
                    end
                end else begin
                    if (count > cfg.min) begin
                        next_count = count - 1'b1;
                        next_dir = DIR_DOWN;
                    end else begin
                        next_count = count + 1'b1;
                        next_dir = DIR_UP;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst_n) begin
            count <= '0;
            direction <= DIR_UP;
            flip_pending <= 1'b0;
        end else begin
            count <= next_count;
            direction <= next_dir;
            flip_pending <= next_pending;
        end
    end

    assign status.count = count;
    assign status.direction = direction;

    a_count_in_range: assert property (@(posedge clk) disable iff (rst_n)
        tick |=> (count >= $past(cfg.min)) && (count <= $past(cfg.max)));

endmodule

/* source/pingpong_macros.svh */
`ifndef PINGPONG_MACROS_SVH
`define PINGPONG_MACROS_SVH

// bus and datapath widths.
`define PP_WIDTH        4
`define PP_ADDR_W       4
`define PP_DATA_W       32
`define PP_PERIOD_W     16

// register map, word aligned.
`define PP_REG_CTRL     4'h0
`define PP_REG_LIMITS   4'h4
`define PP_REG_PERIOD   4'h8
`define PP_REG_FLIP     4'hC
`define PP_REG_STATUS   4'hC   // read side of the flip offset.

`define PP_RESP_OKAY    2'b00
`define PP_RESP_SLVERR  2'b10

`define PP_DEBOUNCE_LEN 4
`define PP_SCAN_DIV     8

`endif

/* source/pingpong_pkg.sv */
`include "pingpong_macros.svh"

package pingpong_pkg;

    typedef logic [`PP_WIDTH-1:0]      count_t;
    typedef logic [`PP_PERIOD_W-1:0]   period_t;
    typedef logic [`PP_ADDR_W-1:0]     axil_addr_t;
    typedef logic [`PP_DATA_W-1:0]     axil_data_t;
    typedef logic [`PP_DATA_W/8-1:0]   axil_strb_t;
    typedef logic [1:0]                axil_resp_t;

    typedef enum logic {DIR_DOWN = 1'b0, DIR_UP = 1'b1} dir_t;

    typedef enum logic {WR_IDLE, WR_RESP} axil_wr_state_t;
    typedef enum logic {RD_IDLE, RD_RESP} axil_rd_state_t;

    typedef struct packed {
        axil_addr_t awaddr;
        logic       awvalid;
        axil_data_t wdata;
        axil_strb_t wstrb;
        logic       wvalid;
        logic       bready;
        axil_addr_t araddr;
        logic       arvalid;
        logic       rready;
    } axil_req_t;

    typedef struct packed {
        logic       awready;
        logic       wready;
        axil_resp_t bresp;
        logic       bvalid;
        logic       arready;
        axil_data_t rdata;
        axil_resp_t rresp;
        logic       rvalid;
    } axil_rsp_t;

    typedef struct packed {
        logic    enable;
        count_t  min;
        count_t  max;
        period_t period;
    } pp_cfg_t;

    typedef struct packed {
        count_t count;
        dir_t   direction;
    } pp_status_t;

endpackage

/* source/pingpong_regs.sv */
`timescale 1ns/1ps
`include "pingpong_macros.svh"

module pingpong_regs (
    input  logic                     clk,
    input  logic                     rst_n,
    input  pingpong_pkg::axil_req_t  axil_req,
    output pingpong_pkg::axil_rsp_t  axil_rsp,
    input  pingpong_pkg::pp_status_t status,
    output pingpong_pkg::pp_cfg_t    cfg,
    output logic                     flip_cmd
);
    import pingpong_pkg::*;

    axil_wr_state_t wr_state;
    axil_rd_state_t rd_state;
    logic           wr_accept;
    logic           wr_known;
    logic           rd_accept;
    logic           rd_known;
    axil_data_t     rd_data;
    axil_data_t     rdata_q;
    axil_resp_t     bresp_q;
    axil_resp_t     rresp_q;

    // address and data are taken together, only while no response is out.
    assign wr_accept = (wr_state == WR_IDLE) && axil_req.awvalid && axil_req.wvalid;
    assign rd_accept = (rd_state == RD_IDLE) && axil_req.arvalid;

    always_comb begin
        case (axil_req.awaddr)
            `PP_REG_CTRL, `PP_REG_LIMITS, `PP_REG_PERIOD, `PP_REG_FLIP:
                wr_known = &axil_req.wstrb;   // full words only.
            default: wr_known = 1'b0;
        endcase
    end

    always_comb begin
        rd_data = '0;
        rd_known = 1'b1;
        case (axil_req.araddr)
            `PP_REG_CTRL:   rd_data[0] = cfg.enable;
            `PP_REG_LIMITS: begin
                rd_data[`PP_WIDTH-1:0] = cfg.min;
                rd_data[8 +: `PP_WIDTH] = cfg.max;
            end
            `PP_REG_PERIOD: rd_data[`PP_PERIOD_W-1:0] = cfg.period;
            `PP_REG_STATUS: begin
                rd_data[`PP_WIDTH-1:0] = status.count;
                rd_data[8] = status.direction;
            end
            default: rd_known = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_n) begin
            wr_state <= WR_IDLE;
            bresp_q <= `PP_RESP_OKAY;
            flip_cmd <= 1'b0;
            cfg.enable <= 1'b0;
            cfg.min <= '0;
            cfg.max <= '0;
            cfg.period <= period_t'(1);
        end else begin
            flip_cmd <= 1'b0;
            case (wr_state)
                WR_IDLE: begin
                    if (wr_accept) begin
                        wr_state <= WR_RESP;
                        bresp_q <= wr_known ? `PP_RESP_OKAY : `PP_RESP_SLVERR;
                        if (wr_known) begin
                            case (axil_req.awaddr)
                                `PP_REG_CTRL:   cfg.enable <= axil_req.wdata[0];
                                `PP_REG_LIMITS: begin
                                    cfg.min <= axil_req.wdata[`PP_WIDTH-1:0];
                                    cfg.max <= axil_req.wdata[8 +: `PP_WIDTH];
                                end
                                `PP_REG_PERIOD: cfg.period <= axil_req.wdata[`PP_PERIOD_W-1:0];
                                default:        flip_cmd <= axil_req.wdata[0];
                            endcase
                        end
                    end
                end
                WR_RESP: begin
                    if (axil_req.bready) wr_state <= WR_IDLE;
                end
                default: wr_state <= WR_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst_n) begin
            rd_state <= RD_IDLE;
            rresp_q <= `PP_RESP_OKAY;
        end else begin
            case (rd_state)
                RD_IDLE: begin
                    if (rd_accept) begin
                        rd_state <= RD_RESP;
                        rresp_q <= rd_known ? `PP_RESP_OKAY : `PP_RESP_SLVERR;
                    end
                end
                RD_RESP: begin
                    if (axil_req.rready) rd_state <= RD_IDLE;
                end
                default: rd_state <= RD_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rd_accept) rdata_q <= rd_data;   // held through back-pressure.
    end

    assign axil_rsp.awready = wr_accept;
    assign axil_rsp.wready  = wr_accept;
    assign axil_rsp.bresp   = bresp_q;
    assign axil_rsp.bvalid  = (wr_state == WR_RESP);
    assign axil_rsp.arready = rd_accept;
    assign axil_rsp.rdata   = rdata_q;
    assign axil_rsp.rresp   = rresp_q;
    assign axil_rsp.rvalid  = (rd_state == RD_RESP);

    a_bvalid_hold: assert property (@(posedge clk) disable iff (rst_n)
        axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid);

    a_rvalid_hold: assert property (@(posedge clk) disable iff (rst_n)
        axil_rsp.rvalid && !axil_req.rready |=> axil_rsp.rvalid && $stable(axil_rsp.rdata));

endmodule

/* source/pingpong_top.sv */
`timescale 1ns/1ps

module pingpong_top (
    input  logic                    clk,
    input  logic                    rst_n,
    input  pingpong_pkg::axil_req_t axil_req,
    output pingpong_pkg::axil_rsp_t axil_rsp,
    input  logic                    btn,
    output pingpong_pkg::count_t    count,
    output logic                    direction,
    output logic [7:0]              seg,
    output logic [3:0]              an
);
    import pingpong_pkg::*;

    pp_cfg_t    cfg;
    pp_status_t status;
    logic       flip_cmd;
    logic       flip_btn;
    logic       step;

    pingpong_regs regs_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .axil_req (axil_req),
        .axil_rsp (axil_rsp),
        .status   (status),
        .cfg      (cfg),
        .flip_cmd (flip_cmd)
    );

    button_conditioner button_i (
        .clk   (clk),
        .rst_n (rst_n),
        .btn   (btn),
        .press (flip_btn)
    );

    step_timer timer_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .enable (cfg.enable),
        .period (cfg.period),
        .step   (step)
    );

    pingpong_counter counter_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .step     (step),
        .flip_cmd (flip_cmd),
        .flip_btn (flip_btn),
        .cfg      (cfg),
        .status   (status)
    );

    seg_scan scan_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .status (status),
        .seg    (seg),
        .an     (an)
    );

    assign count = status.count;   // led outputs.
    assign direction = status.direction;

endmodule

/* source/seg_scan.sv */
`timescale 1ns/1ps
`include "pingpong_macros.svh"

module seg_scan #(
    parameter int SCAN_DIV = `PP_SCAN_DIV
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  pingpong_pkg::pp_status_t status,
    output logic [7:0]               seg,
    output logic [3:0]               an
);
    import pingpong_pkg::*;

    localparam int DIV_W = $clog2(SCAN_DIV + 1);

    // active low, a..g then dp in bit 0.
    localparam logic [7:0] SEG_UP   = 8'b0011_1011;
    localparam logic [7:0] SEG_DOWN = 8'b1100_0111;

    logic [DIV_W-1:0] div_cnt;
    logic             scan_tick;
    logic [1:0]       digit;
    logic             tens;
    count_t           ones;
    logic [7:0]       seg_next;

    function automatic logic [7:0] seg_code(input logic [3:0] value);
        case (value)
            4'd0:    seg_code = 8'b0000_0011;
            4'd1:    seg_code = 8'b1001_1111;
            4'd2:    seg_code = 8'b0010_0101;
            4'd3:    seg_code = 8'b0000_1101;
            4'd4:    seg_code = 8'b1001_1001;
            4'd5:    seg_code = 8'b0100_1001;
            4'd6:    seg_code = 8'b0100_0001;
            4'd7:    seg_code = 8'b0001_1111;
            4'd8:    seg_code = 8'b0000_0001;
            4'd9:    seg_code = 8'b0000_1001;
            default: seg_code = 8'b1111_1111;
        endcase
    endfunction

    assign scan_tick = (div_cnt == DIV_W'(SCAN_DIV - 1));
    assign tens = (status.count >= count_t'(10));
    assign ones = tens ? status.count - count_t'(10) : status.count;

    always_comb begin
        case (digit)
            2'd0:    seg_next = seg_code(ones);
            2'd1:    seg_next = seg_code({3'b000, tens});
            default: seg_next = (status.direction == DIR_UP) ? SEG_UP : SEG_DOWN;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_n) begin
            div_cnt <= '0;
            digit <= 2'd0;
            seg <= 8'hFF;
            an <= 4'hF;   // dark until the first tick.
        end else begin
            div_cnt <= scan_tick ? '0 : div_cnt + 1'b1;
            if (scan_tick) begin
                digit <= digit + 1'b1;
                seg <= seg_next;
                an <= ~(4'b0001 << digit);
            end
        end
    end

endmodule

/* source/step_timer.sv */
`timescale 1ns/1ps

module step_timer (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  enable,
    input  pingpong_pkg::period_t period,
    output logic                  step
);
    import pingpong_pkg::*;

    period_t remain;
    period_t reload;

    assign reload = (period == '0) ? period_t'(1) : period;

    always_ff @(posedge clk) begin
        if (rst_n) begin
            remain <= period_t'(1);
            step <= 1'b0;
        end else if (!enable) begin
            remain <= reload;
            step <= 1'b0;
        end else if (remain <= period_t'(1)) begin
            remain <= reload;
            step <= 1'b1;
        end else begin
            remain <= remain - 1'b1;
            step <= 1'b0;
        end
    end

    // back-to-back ticks only when the loaded period was one.
    a_step_spacing: assert property (@(posedge clk) disable iff (rst_n)
        step && $past(step) |-> $past(reload, 2) == period_t'(1));

endmodule
